// ==== rtl/fog_pkg.sv ====
// fog loop shared definitions
`default_nettype none

package fog_pkg;

	// phase word driven to the modulator dac
	localparam int DAC_WIDTH = 16;

	// signed ramp step and accumulator word
	typedef logic signed [31:0] step_t;

	// dac limits, +pi and -pi
	localparam step_t PHASE_MAX = 32'sd32767;
	localparam step_t PHASE_MIN = -32'sd32768;

	// one full 2pi span in dac codes
	localparam step_t PHASE_SPAN = 32'sd65536;

	// gain shift after reset
	localparam logic [4:0] GAIN_INIT = 5'd5;

	// feedback modes of the ramp generator
	typedef enum logic [1:0] {
		// square wave only
		FB_OPEN   = 2'd0,
		// closed loop ramp plus bias
		FB_CLOSED = 2'd1,
		// staircase test pattern
		FB_STAIR  = 2'd2,
		// freeze the phase word
		FB_HOLD   = 2'd3
	} fb_mode_e;

endpackage

`default_nettype wire

// ==== rtl/loop_trig_if.sv ====
// loop trigger bus
`timescale 1ns/10ps
`default_nettype none

interface loop_trig_if import fog_pkg::*; ();

	// bias amplitude, fed in from the top level
	logic signed [DAC_WIDTH-1:0] mod_amp;

	// single cycle strobes from the eigen-period counter
	logic rate_trig;
	logic ramp_trig;
	logic mod_trig;
	logic period_end;

	// high in the positive half period
	logic mod_sign;
	// bias value, +amp or -amp
	logic signed [DAC_WIDTH-1:0] mod_value;

	// timing generator side
	modport src (
		input  mod_amp,
		output rate_trig, ramp_trig, mod_trig, period_end, mod_sign, mod_value
	);

	// ramp generator side
	modport ramp (
		input rate_trig, ramp_trig, mod_trig, mod_value
	);

	// demodulator side
	modport demod (
		input mod_sign, period_end
	);

endinterface

`default_nettype wire

// ==== rtl/loop_timing_gen.sv ====
// eigen-period timing generator
`timescale 1ns/10ps
`default_nettype none

module loop_timing_gen #(
	// clocks per half period, at least 6
	parameter int TAU_CYCLES = 8
) (
	input  wire         i_clk,
	input  wire         i_rst_n,
	loop_trig_if.src    trig
);

	localparam int PERIOD = 2 * TAU_CYCLES;
	localparam int CNT_W  = $clog2(PERIOD);

	// count decode points
	localparam logic [CNT_W-1:0] CNT_RATE  = CNT_W'(0);
	localparam logic [CNT_W-1:0] CNT_RAMP  = CNT_W'(1);
	localparam logic [CNT_W-1:0] CNT_MOD_P = CNT_W'(2);
	localparam logic [CNT_W-1:0] CNT_MOD_N = CNT_W'(TAU_CYCLES + 2);
	localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(PERIOD - 1);
	localparam logic [CNT_W-1:0] CNT_HALF  = CNT_W'(TAU_CYCLES);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic             pos_nxt;

	// modulo 2*tau count
	always_comb begin
		if (cnt == CNT_LAST) begin
			cnt_nxt = '0;
		end else begin
			cnt_nxt = cnt + CNT_W'(1);
		end
		// first half is the positive bias
		pos_nxt = (cnt_nxt < CNT_HALF);
	end

	// strobes registered against the next count
	// so they line up with the count they belong to
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// parked on the last count, first edge lands on 0
			cnt             <= CNT_LAST;
			trig.rate_trig  <= 1'b0;
			trig.ramp_trig  <= 1'b0;
			trig.mod_trig   <= 1'b0;
			trig.period_end <= 1'b0;
			trig.mod_sign   <= 1'b0;
			trig.mod_value  <= '0;
		end else begin
			cnt             <= cnt_nxt;
			trig.rate_trig  <= (cnt_nxt == CNT_RATE);
			trig.ramp_trig  <= (cnt_nxt == CNT_RAMP);
			// one bias step per half period
			trig.mod_trig   <= (cnt_nxt == CNT_MOD_P) || (cnt_nxt == CNT_MOD_N);
			trig.period_end <= (cnt_nxt == CNT_LAST);
			trig.mod_sign   <= pos_nxt;
			// square wave bias
			if (pos_nxt) begin
				trig.mod_value <= trig.mod_amp;
			end else begin
				trig.mod_value <= -trig.mod_amp;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/error_demod.sv ====
// detector error demodulator
`timescale 1ns/10ps
`default_nettype none

module error_demod import fog_pkg::*; #(
	// sum to step scaling
	parameter int DEMOD_SHIFT = 2
) (
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  wire signed [15:0] i_adc_data,
	loop_trig_if.demod        trig,
	output step_t             o_step
);

	// running sum over one eigen-period
	step_t sum;
	// signed sample contribution
	step_t contrib;
	// sum including the current sample
	step_t sum_nxt;
	// low until the counter has started
	logic  armed;

	always_comb begin
		// multiply by the bias sign
		if (trig.mod_sign) begin
			contrib = step_t'(i_adc_data);
		end else begin
			contrib = -step_t'(i_adc_data);
		end
		sum_nxt = sum + contrib;
	end

	// armed skips the cycle before count 0
	// so each sum spans exactly one period
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum    <= '0;
			o_step <= '0;
		end else if (trig.period_end) begin
			// publish the full period, last sample included
			o_step <= sum_nxt >>> DEMOD_SHIFT;
			// restart for the next period
			sum    <= '0;
		end else if (armed) begin
			sum <= sum_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/phase_ramp_gen.sv ====
// phase ramp generator
`timescale 1ns/10ps
`default_nettype none

module phase_ramp_gen import fog_pkg::*; (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	loop_trig_if.ramp                    trig,
	input  step_t                        i_step,
	input  fb_mode_e                     i_fb_mode,
	input  wire        [4:0]             i_gain_sel,
	output logic signed [DAC_WIDTH-1:0]  o_phase,
	output logic                         o_phase_update,
	output logic                         o_ramp_reset
);

	// registered configuration
	fb_mode_e   mode_q;
	logic [4:0] gain_q;

	// step accumulator, full resolution
	step_t acc;
	// accumulator scaled down by the gain
	step_t ramp;

	// closed loop phase candidate and its wrap
	step_t sum;
	step_t sum_w;
	step_t ramp_w;
	step_t acc_w;
	logic  wrap;
	// 2pi expressed at accumulator scale
	step_t span_acc;
	// stair pattern next value
	step_t stair;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode_q <= FB_OPEN;
			gain_q <= GAIN_INIT;
		end else begin
			mode_q <= i_fb_mode;
			gain_q <= i_gain_sel;
		end
	end

	always_comb begin
		span_acc = PHASE_SPAN <<< gain_q;
		sum      = ramp + step_t'(trig.mod_value);
		sum_w    = sum;
		ramp_w   = ramp;
		acc_w    = acc;
		wrap     = 1'b0;
		// above +pi, drop one span
		if (sum > PHASE_MAX) begin
			sum_w  = sum - PHASE_SPAN;
			ramp_w = ramp - PHASE_SPAN;
			acc_w  = acc - span_acc;
			wrap   = 1'b1;
		// below -pi, add one span
		end else if (sum < PHASE_MIN) begin
			sum_w  = sum + PHASE_SPAN;
			ramp_w = ramp + PHASE_SPAN;
			acc_w  = acc + span_acc;
			wrap   = 1'b1;
		end
		// truncation to the dac width wraps by one span
		stair = step_t'(o_phase) + i_step;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			acc            <= '0;
			ramp           <= '0;
			o_phase        <= '0;
			o_phase_update <= 1'b0;
			o_ramp_reset   <= 1'b0;
		end else begin
			// strobes last one cycle
			o_phase_update <= 1'b0;
			o_ramp_reset   <= 1'b0;
			case (mode_q)
				FB_OPEN: begin
					// no feedback, bias only
					acc  <= '0;
					ramp <= '0;
					if (trig.mod_trig) begin
						o_phase        <= trig.mod_value;
						o_phase_update <= 1'b1;
					end
				end
				FB_CLOSED: begin
					// triggers sit in separate counts
					if (trig.rate_trig) begin
						acc <= acc + i_step;
					end else if (trig.ramp_trig) begin
						ramp <= acc >>> gain_q;
					end else if (trig.mod_trig) begin
						acc            <= acc_w;
						ramp           <= ramp_w;
						o_phase        <= sum_w[DAC_WIDTH-1:0];
						o_phase_update <= 1'b1;
						o_ramp_reset   <= wrap;
					end
				end
				FB_STAIR: begin
					if (trig.mod_trig) begin
						o_phase        <= stair[DAC_WIDTH-1:0];
						o_phase_update <= 1'b1;
					end
				end
				default: begin
					// hold, phase and ramp frozen
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dac_req_ack.sv ====
// dac four-phase req/ack driver
`timescale 1ns/10ps
`default_nettype none

module dac_req_ack import fog_pkg::*; (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  wire signed [DAC_WIDTH-1:0] i_phase,
	input  wire                        i_phase_update,
	output logic                       o_dac_req,
	output logic       [DAC_WIDTH-1:0] o_dac_data,
	input  wire                        i_dac_ack
);

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_WAIT_HI = 2'd1,
		ST_WAIT_LO = 2'd2
	} dac_state_e;

	dac_state_e           state;
	logic                 pend_valid;
	logic [DAC_WIDTH-1:0] pend_data;
	// bus free for a new request this cycle
	logic                 free;
	logic                 launch;
	logic                 launch_new;

	always_comb begin
		// ack must be seen low before req may rise again
		free       = (state == ST_IDLE) || ((state == ST_WAIT_LO) && !i_dac_ack);
		// newest word goes first, older pending one is dropped
		launch_new = free && i_phase_update;
		launch     = free && (i_phase_update || pend_valid);
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			o_dac_req  <= 1'b0;
			pend_valid <= 1'b0;
		end else if (free) begin
			o_dac_req  <= launch;
			pend_valid <= 1'b0;
			state      <= launch ? ST_WAIT_HI : ST_IDLE;
		end else begin
			// transfer in flight, park the update
			if (i_phase_update) begin
				pend_valid <= 1'b1;
			end
			if ((state == ST_WAIT_HI) && i_dac_ack) begin
				o_dac_req <= 1'b0;
				state     <= ST_WAIT_LO;
			end
		end
	end

	// data only changes when a request starts
	always_ff @(posedge i_clk) begin
		if (launch_new) begin
			o_dac_data <= i_phase;
		end else if (launch) begin
			o_dac_data <= pend_data;
		end
		if (!free && i_phase_update) begin
			pend_data <= i_phase;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fog_loop_top.sv ====
// fog closed loop top
`timescale 1ns/10ps
`default_nettype none

module fog_loop_top import fog_pkg::*; #(
	parameter int TAU_CYCLES  = 8,
	parameter int DEMOD_SHIFT = 2
) (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire  signed [15:0]          i_adc_data,
	input  fb_mode_e                    i_fb_mode,
	input  wire         [4:0]           i_gain_sel,
	input  wire  signed [DAC_WIDTH-1:0] i_mod_amp,
	output logic signed [DAC_WIDTH-1:0] o_phase_ramp,
	output logic                        o_phase_update,
	output logic                        o_ramp_reset,
	output logic                        o_dac_req,
	output logic        [DAC_WIDTH-1:0] o_dac_data,
	input  wire                         i_dac_ack
);

	// demodulated rate step into the ramp
	step_t step;

	loop_trig_if trig_bus ();

	// bias amplitude enters the loop here
	assign trig_bus.mod_amp = i_mod_amp;

	// sole source of loop timing
	loop_timing_gen #(
		.TAU_CYCLES (TAU_CYCLES)
	) u_timing (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.trig    (trig_bus.src)
	);

	error_demod #(
		.DEMOD_SHIFT (DEMOD_SHIFT)
	) u_demod (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_adc_data (i_adc_data),
		.trig       (trig_bus.demod),
		.o_step     (step)
	);

	phase_ramp_gen u_ramp (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.trig           (trig_bus.ramp),
		.i_step         (step),
		.i_fb_mode      (i_fb_mode),
		.i_gain_sel     (i_gain_sel),
		.o_phase        (o_phase_ramp),
		.o_phase_update (o_phase_update),
		.o_ramp_reset   (o_ramp_reset)
	);

	// phase words out to the modulator dac
	dac_req_ack u_dac (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_phase        (o_phase_ramp),
		.i_phase_update (o_phase_update),
		.o_dac_req      (o_dac_req),
		.o_dac_data     (o_dac_data),
		.i_dac_ack      (i_dac_ack)
	);

endmodule

`default_nettype wire

// ==== sim/tb_fog_loop.sv ====
// fog loop testbench
`timescale 1ns/10ps
`default_nettype none

module tb_fog_loop import fog_pkg::*; ;

	localparam int TAU = 8;
	localparam int SHIFT = 2;
	localparam int PER = 2 * TAU;
	// periods run by all tests together
	localparam int TOTAL_PERIODS = 6 + 40 + 80 + 30 + 30 + 20 + 4;
	localparam int TOTAL_CYCLES = TOTAL_PERIODS * PER + 7 * 8;

	logic                        clk;
	logic                        rst_n;
	logic signed [15:0]          adc;
	fb_mode_e                    cfg_mode;
	logic        [4:0]           cfg_gain;
	logic signed [DAC_WIDTH-1:0] cfg_amp;
	logic                        dac_ack;
	wire signed  [DAC_WIDTH-1:0] phase_ramp;
	wire                         phase_update;
	wire                         ramp_reset;
	wire                         dac_req;
	wire         [DAC_WIDTH-1:0] dac_data;

	// stimulus shaping, set while reset is held
	int adc_mag;
	int adc_bias;

	// loop model state
	int                          m_cnt;
	step_t                       m_sum;
	step_t                       m_step;
	step_t                       m_acc;
	step_t                       m_ramp;
	logic signed [DAC_WIDTH-1:0] m_phase;
	logic                        m_upd;
	logic                        m_wrap;
	fb_mode_e                    m_mode;
	logic        [4:0]           m_gain;
	logic        [DAC_WIDTH-1:0] exp_q[$];

	int upd_cnt;
	int wrap_cnt;

	// dac responder state
	logic [31:0]          rng;
	logic [31:0]          ack_rng;
	int                   ack_dly;
	logic                 prev_req;
	logic                 prev_ack;
	logic [DAC_WIDTH-1:0] prev_data;

	fog_loop_top #(
		.TAU_CYCLES  (TAU),
		.DEMOD_SHIFT (SHIFT)
	) uut (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_adc_data     (adc),
		.i_fb_mode      (cfg_mode),
		.i_gain_sel     (cfg_gain),
		.i_mod_amp      (cfg_amp),
		.o_phase_ramp   (phase_ramp),
		.o_phase_update (phase_update),
		.o_ramp_reset   (ramp_reset),
		.o_dac_req      (dac_req),
		.o_dac_data     (dac_data),
		.i_dac_ack      (dac_ack)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic mismatch(input string name, input longint got, input longint exp);
		$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic fail_plain(input string what);
		$display("%0t: %s", $time, what);
		$display("sim failed");
		$fatal(1);
	endtask

	// one clock of the loop, counts as in the timing rules
	task automatic model_step();
		int          c;
		logic        pos;
		step_t       modv;
		step_t       contrib;
		step_t       s;
		c = m_cnt;
		pos = (c >= 0) && (c < TAU);
		modv = (c < 0) ? 0 : (pos ? step_t'(cfg_amp) : -step_t'(cfg_amp));
		m_upd = 1'b0;
		m_wrap = 1'b0;
		case (m_mode)
			FB_OPEN: begin
				m_acc = 0;
				m_ramp = 0;
				if (c == 2 || c == TAU + 2) begin
					m_phase = modv[DAC_WIDTH-1:0];
					m_upd = 1'b1;
				end
			end
			FB_CLOSED: begin
				if (c == 0) begin
					m_acc = m_acc + m_step;
				end else if (c == 1) begin
					m_ramp = m_acc >>> m_gain;
				end else if (c == 2 || c == TAU + 2) begin
					s = m_ramp + modv;
					if (s > 32767) begin
						s = s - 65536;
						m_ramp = m_ramp - 65536;
						m_acc = m_acc - (step_t'(65536) <<< m_gain);
						m_wrap = 1'b1;
					end else if (s < -32768) begin
						s = s + 65536;
						m_ramp = m_ramp + 65536;
						m_acc = m_acc + (step_t'(65536) <<< m_gain);
						m_wrap = 1'b1;
					end
					assert (s >= -32768 && s <= 32767)
					else fail_plain("wrapped phase left the dac range");
					m_phase = s[DAC_WIDTH-1:0];
					m_upd = 1'b1;
				end
			end
			FB_STAIR: begin
				if (c == 2 || c == TAU + 2) begin
					m_phase = m_phase + m_step[DAC_WIDTH-1:0];
					m_upd = 1'b1;
				end
			end
			default: begin
			end
		endcase
		if (m_upd) begin
			exp_q.push_back(m_phase);
		end
		// demodulator, old step already used above
		contrib = pos ? step_t'(adc) : -step_t'(adc);
		if (c == PER - 1) begin
			m_step = (m_sum + contrib) >>> SHIFT;
			m_sum = 0;
		end else if (c >= 0) begin
			m_sum = m_sum + contrib;
		end
		m_mode = cfg_mode;
		m_gain = cfg_gain;
		m_cnt = (c == PER - 1) ? 0 : c + 1;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			m_cnt = -1;
			m_sum = 0;
			m_step = 0;
			m_acc = 0;
			m_ramp = 0;
			m_phase = 0;
			m_upd = 1'b0;
			m_wrap = 1'b0;
			m_mode = FB_OPEN;
			m_gain = GAIN_INIT;
			exp_q.delete();
		end else begin
			assert (phase_ramp == m_phase)
			else mismatch("o_phase_ramp", phase_ramp, m_phase);
			assert (phase_update == m_upd)
			else mismatch("o_phase_update", phase_update, m_upd);
			assert (ramp_reset == m_wrap)
			else mismatch("o_ramp_reset", ramp_reset, m_wrap);
			if (phase_update) begin
				upd_cnt++;
			end
			if (ramp_reset) begin
				wrap_cnt++;
			end
			model_step();
		end
		// next sample, bias follows the sign of the coming count
		rng = xorshift(rng);
		adc <= 16'(int'(rng % 32'(2 * adc_mag + 1)) - adc_mag
			+ ((m_cnt >= 0 && m_cnt < TAU) ? adc_bias : -adc_bias));
	end

	// dac responder with 0 to 2 cycle delays
	always @(posedge clk) begin
		if (!rst_n) begin
			dac_ack <= 1'b0;
			ack_dly = 0;
			prev_req = 1'b0;
			prev_ack = 1'b0;
		end else begin
			if (dac_req && !prev_req) begin
				assert (!prev_ack) else fail_plain("dac req rose while ack was high");
			end
			if (!dac_req && prev_req) begin
				assert (prev_ack) else fail_plain("dac req fell before ack");
			end
			if (dac_req && prev_req) begin
				assert (dac_data == prev_data)
				else mismatch("o_dac_data", dac_data, prev_data);
			end
			if (dac_req && !dac_ack) begin
				if (ack_dly == 0) begin
					assert (exp_q.size() > 0) else fail_plain("dac word with none expected");
					assert (dac_data == exp_q[0])
					else mismatch("o_dac_data", dac_data, exp_q[0]);
					void'(exp_q.pop_front());
					dac_ack <= 1'b1;
					ack_rng = xorshift(ack_rng);
					ack_dly = int'(ack_rng % 3);
				end else begin
					ack_dly--;
				end
			end else if (!dac_req && dac_ack) begin
				if (ack_dly == 0) begin
					dac_ack <= 1'b0;
					ack_rng = xorshift(ack_rng);
					ack_dly = int'(ack_rng % 3);
				end else begin
					ack_dly--;
				end
			end
			prev_req = dac_req;
			prev_ack = dac_ack;
			prev_data = dac_data;
		end
	end

	// reset with a new configuration, then run whole periods
	task automatic run_phase(input fb_mode_e mode, input int gain, input int amp,
		input int mag, input int bias, input int periods);
		@(posedge clk);
		rst_n <= 1'b0;
		cfg_mode <= mode;
		cfg_gain <= 5'(gain);
		cfg_amp <= 16'(amp);
		adc_mag = mag;
		adc_bias = bias;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		upd_cnt = 0;
		wrap_cnt = 0;
		@(posedge clk);
		assert (dac_req == 1'b0) else mismatch("o_dac_req", dac_req, 0);
		repeat (periods * PER) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		adc = '0;
		cfg_mode = FB_OPEN;
		cfg_gain = GAIN_INIT;
		cfg_amp = '0;
		dac_ack = 1'b0;
		adc_mag = 0;
		adc_bias = 0;
		rng = 32'ha8a7_ff7b;
		ack_rng = xorshift(32'ha8a7_ff7b ^ 32'h5555_aaaa);
		// open loop square wave
		run_phase(FB_OPEN, 5, 1200, 500, 0, 6);
		assert (upd_cnt > 0) else fail_plain("no phase updates in open mode");
		// closed loop, random detector error
		run_phase(FB_CLOSED, 5, 900, 2000, 0, 40);
		// closed loop, strong rate so the ramp wraps
		run_phase(FB_CLOSED, 2, 3000, 100, 2000, 80);
		assert (wrap_cnt > 0) else fail_plain("no ramp wrap with a large rate");
		// gain extremes
		run_phase(FB_CLOSED, 0, 700, 500, 0, 30);
		run_phase(FB_CLOSED, 9, 700, 4000, 0, 30);
		// staircase, then hold
		run_phase(FB_STAIR, 5, 0, 1000, 0, 20);
		assert (upd_cnt > 0) else fail_plain("no phase updates in stair mode");
		run_phase(FB_HOLD, 5, 1500, 1000, 0, 4);
		assert (upd_cnt == 0) else mismatch("update count in hold", upd_cnt, 0);
		$display("sim passed");
		$finish;
	end

	// watchdog sized from the test lengths with margin
	initial begin
		#(longint'(TOTAL_CYCLES) * 40 * 2);
		$display("timeout, the tests did not finish in time");
		$display("sim failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/fog_pkg.sv
rtl/loop_trig_if.sv
rtl/loop_timing_gen.sv
rtl/error_demod.sv
rtl/phase_ramp_gen.sv
rtl/dac_req_ack.sv
rtl/fog_loop_top.sv
sim/tb_fog_loop.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fog loop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_fog_loop -o sim_fog

out=$(./obj_dir/sim_fog 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
else
	exit 1
fi
